//--- design/periph_pkg.sv
/* Shared definitions for the peripheral configuration subsystem. Bus widths,
   the address map, register-bus structs, the FLL config word and the boot image. */
package periph_pkg;

  // ==============================
  // widths and address map
  // ==============================
  localparam int unsigned AddrWidth = 16;  // apb byte address.
  localparam int unsigned DataWidth = 32;

  localparam logic [DataWidth-1:0] BootromBase = 32'h0000_0000;
  localparam logic [DataWidth-1:0] BootromSize = 32'h0000_1000;  // 4 KiB.
  localparam logic [DataWidth-1:0] FllBase     = 32'h0000_1000;
  localparam logic [DataWidth-1:0] FllSize     = 32'h0000_0100;  // one slot per fll.
  localparam logic [DataWidth-1:0] FllWindow   = 32'h0000_1000;  // room for 16 slots.
  localparam logic [DataWidth-1:0] MemBase     = 32'h0000_8000;
  localparam logic [DataWidth-1:0] MemSize     = 32'h0000_8000;  // 32 KiB.

  // ==============================
  // register bus
  // ==============================
  typedef struct packed {
    logic [DataWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic                 write;
    logic                 valid;
  } reg_req_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 ready;
    logic                 error;
  } reg_rsp_t;

  // the mode bit of the FLL config word selects the view (1 = closed loop).
  typedef struct packed {
    logic        mode;
    logic        enable;
    logic [13:0] rsvd;
    logic [15:0] dco;
  } fll_open_t;

  typedef struct packed {
    logic        mode;
    logic        enable;
    logic [15:0] rsvd;
    logic [9:0]  mult;
    logic [3:0]  div_exp;
  } fll_closed_t;

  typedef union packed {
    fll_open_t   open_loop;
    fll_closed_t closed_loop;
  } fll_cfg_u;

  // ==============================
  // boot image
  // ==============================
  localparam int unsigned BootWords = 16;

  function automatic logic [BootWords-1:0][DataWidth-1:0] boot_image_init();
    logic [BootWords-1:0][DataWidth-1:0] img;
    for (int k = 0; k < BootWords; k++) begin
      img[k] = 32'hB007_0000 + k;
    end
    return img;
  endfunction

  localparam logic [BootWords-1:0][DataWidth-1:0] BootImage = boot_image_init();

endpackage

//--- design/apb_to_reg.sv
/* APB completer front end. Turns the access phase into one register-bus
   request and maps the register-bus response back onto pready, prdata and pslverr. */
module apb_to_reg (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [periph_pkg::AddrWidth-1:0] paddr_i,
  input  logic [periph_pkg::DataWidth-1:0] pwdata_i,
  output logic [periph_pkg::DataWidth-1:0] prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  output periph_pkg::reg_req_t             reg_req_o,
  input  periph_pkg::reg_rsp_t             reg_rsp_i
);

  localparam int unsigned PadWidth = periph_pkg::DataWidth - periph_pkg::AddrWidth;

  logic access;
  logic done_q;

  assign access = psel_i & penable_i;

  // ==============================
  // request side
  // ==============================
  always_comb begin
    reg_req_o.addr  = {{PadWidth{1'b0}}, paddr_i};  // zero extend to a full word.
    reg_req_o.wdata = pwdata_i;
    reg_req_o.write = pwrite_i;
    reg_req_o.valid = access & ~done_q;              // no reissue after ready.
  end

  // set for exactly the cycle after a completed transfer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= reg_req_o.valid & reg_rsp_i.ready;
    end
  end

  // ==============================
  // response side
  // ==============================
  assign pready_o  = access & reg_rsp_i.ready;
  assign prdata_o  = reg_rsp_i.rdata;   // only meaningful with pready.
  assign pslverr_o = reg_rsp_i.error;

endmodule

//--- design/periph_addr_decode.sv
/* Register-bus address decoder. Forwards a request to exactly one target with
   the address rebased to its region, and answers unmapped accesses with an error. */
module periph_addr_decode #(
  parameter int unsigned NumFll = 3
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  periph_pkg::reg_req_t req_i,
  output periph_pkg::reg_rsp_t rsp_o,
  output periph_pkg::reg_req_t rom_req_o,
  input  periph_pkg::reg_rsp_t rom_rsp_i,
  output periph_pkg::reg_req_t fll_req_o [NumFll],
  input  periph_pkg::reg_rsp_t fll_rsp_i [NumFll],
  output periph_pkg::reg_req_t mem_req_o,
  input  periph_pkg::reg_rsp_t mem_rsp_i
);

  localparam int unsigned IdxWidth = $clog2(periph_pkg::FllWindow / periph_pkg::FllSize);

  logic [periph_pkg::DataWidth-1:0] rom_off;
  logic [periph_pkg::DataWidth-1:0] fll_off;
  logic [periph_pkg::DataWidth-1:0] mem_off;
  logic [IdxWidth-1:0]              fll_idx;
  logic                             sel_rom;
  logic                             sel_fll;
  logic                             sel_mem;
  logic                             sel_none;
  logic                             err_q;

  // offsets wrap below the base, so one compare covers the region.
  assign rom_off = req_i.addr - periph_pkg::BootromBase;
  assign fll_off = req_i.addr - periph_pkg::FllBase;
  assign mem_off = req_i.addr - periph_pkg::MemBase;
  assign fll_idx = fll_off[$clog2(periph_pkg::FllSize) +: IdxWidth];

  assign sel_rom  = rom_off < periph_pkg::BootromSize;
  assign sel_fll  = (fll_off < periph_pkg::FllWindow) && (fll_idx < NumFll);
  assign sel_mem  = mem_off < periph_pkg::MemSize;
  assign sel_none = ~(sel_rom | sel_fll | sel_mem);

  // ==============================
  // request fan-out
  // ==============================
  always_comb begin
    rom_req_o       = req_i;
    rom_req_o.addr  = rom_off;
    rom_req_o.valid = req_i.valid & sel_rom;
    mem_req_o       = req_i;
    mem_req_o.addr  = mem_off;
    mem_req_o.valid = req_i.valid & sel_mem;
    for (int n = 0; n < NumFll; n++) begin
      fll_req_o[n]       = req_i;
      fll_req_o[n].addr  = fll_off & (periph_pkg::FllSize - 1);
      fll_req_o[n].valid = req_i.valid & sel_fll & (fll_idx == n);
    end
  end

  // one-cycle error responder for holes in the map
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req_i.valid & sel_none & ~err_q;
    end
  end

  // ==============================
  // response mux
  // ==============================
  always_comb begin
    rsp_o = '0;
    if (sel_rom) begin
      rsp_o = rom_rsp_i;
    end else if (sel_mem) begin
      rsp_o = mem_rsp_i;
    end else if (sel_fll) begin
      for (int n = 0; n < NumFll; n++) begin
        if (fll_idx == n) rsp_o = fll_rsp_i[n];
      end
    end else begin
      rsp_o.ready = err_q;
      rsp_o.error = err_q;
    end
  end

endmodule

//--- design/bootrom_regs.sv
/* Boot ROM target. Serves the boot image by word index one cycle after the
   request; writes complete with an error and change nothing. */
module bootrom_regs (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  periph_pkg::reg_req_t req_i,
  output periph_pkg::reg_rsp_t rsp_o
);

  logic [9:0]                       word_idx;
  logic [periph_pkg::DataWidth-1:0] word;
  logic                             accept;
  logic                             ready_q;
  logic                             err_q;
  logic [periph_pkg::DataWidth-1:0] rdata_q;

  assign word_idx = req_i.addr[11:2];  // word index within the 4 KiB region.
  assign accept   = req_i.valid & ~ready_q;

  // past the stub the region reads as zero
  always_comb begin
    word = '0;
    if (word_idx < periph_pkg::BootWords) begin
      word = periph_pkg::BootImage[word_idx[3:0]];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      ready_q <= accept;
      err_q   <= accept & req_i.write;  // read only.
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= word;
    end
  end

  assign rsp_o = '{rdata: rdata_q, ready: ready_q, error: err_q};

endmodule

//--- design/fll_regs.sv
/* Configuration and status registers of one FLL. CFG at 0x0, STATUS at 0x4;
   an enabling CFG write restarts the lock-settling counter. */
module fll_regs #(
  parameter int unsigned SettleCycles = 20
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  periph_pkg::reg_req_t req_i,
  output periph_pkg::reg_rsp_t rsp_o,
  output periph_pkg::fll_cfg_u clk_cfg_o,
  output logic                 locked_o
);

  localparam int unsigned CntWidth     = $clog2(SettleCycles + 1);
  localparam logic [7:0]  CfgOffset    = 8'h00;
  localparam logic [7:0]  StatusOffset = 8'h04;

  periph_pkg::fll_cfg_u             cfg_q;
  periph_pkg::fll_cfg_u             wr_cfg;
  logic [CntWidth-1:0]              cnt_q;
  logic                             locked_q;
  logic                             ready_q;
  logic                             err_q;
  logic [periph_pkg::DataWidth-1:0] rdata_q;
  logic                             accept;
  logic                             hit_cfg;
  logic                             hit_status;
  logic                             bad;
  logic [15:0]                      loop_val;
  logic [periph_pkg::DataWidth-1:0] status;

  assign wr_cfg     = req_i.wdata;
  assign accept     = req_i.valid & ~ready_q;
  assign hit_cfg    = req_i.addr[7:0] == CfgOffset;
  assign hit_status = req_i.addr[7:0] == StatusOffset;
  assign bad        = ~(hit_cfg | hit_status) | (hit_status & req_i.write);

  // ==============================
  // status word
  // ==============================
  always_comb begin
    if (cfg_q.closed_loop.mode) begin
      loop_val = 16'(cfg_q.closed_loop.mult >> cfg_q.closed_loop.div_exp);
    end else begin
      loop_val = cfg_q.open_loop.dco;
    end
  end

  assign status = {loop_val, 15'b0, locked_q};

  // ==============================
  // config and lock state
  // ==============================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_q    <= '0;
      cnt_q    <= '0;
      locked_q <= 1'b0;
      ready_q  <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      ready_q <= accept;
      err_q   <= accept & bad;
      if (accept && req_i.write && hit_cfg) begin
        cfg_q    <= wr_cfg;
        locked_q <= 1'b0;  // relock from scratch.
        cnt_q    <= wr_cfg.open_loop.enable ? CntWidth'(SettleCycles) : '0;
      end else begin
        if (cnt_q != '0) cnt_q <= cnt_q - 1'b1;
        locked_q <= cfg_q.open_loop.enable & (cnt_q == '0);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (hit_cfg) begin
        rdata_q <= cfg_q;
      end else if (hit_status) begin
        rdata_q <= status;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rsp_o     = '{rdata: rdata_q, ready: ready_q, error: err_q};
  assign clk_cfg_o = cfg_q;
  assign locked_o  = locked_q;

endmodule

//--- design/regbus_mem.sv
/* Word-addressed scratch memory on the register bus. A request is taken at
   once and answered MemLatency cycles later; the word index wraps within Words. */
module regbus_mem #(
  parameter int unsigned Words      = 256,
  parameter int unsigned MemLatency = 3
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  periph_pkg::reg_req_t req_i,
  output periph_pkg::reg_rsp_t rsp_o
);

  localparam int unsigned IdxWidth = $clog2(Words);
  localparam int unsigned CntWidth = $clog2(MemLatency + 1);

  logic [periph_pkg::DataWidth-1:0] mem_q [Words];
  logic [periph_pkg::DataWidth-1:0] rdata_q;
  logic [IdxWidth-1:0]              idx;
  logic [CntWidth-1:0]              cnt_q;
  logic                             busy_q;
  logic                             accept;
  logic                             ready;

  assign idx    = req_i.addr[2 +: IdxWidth];
  assign accept = req_i.valid & ~busy_q;
  assign ready  = busy_q & (cnt_q == '0);

  // ==============================
  // latency counter
  // ==============================
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      cnt_q  <= CntWidth'(MemLatency - 1);
    end else if (busy_q) begin
      if (cnt_q == '0) begin
        busy_q <= 1'b0;  // response delivered this cycle.
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // array access happens at acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (req_i.write) begin
        mem_q[idx] <= req_i.wdata;
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign rsp_o = '{rdata: rdata_q, ready: ready, error: 1'b0};

endmodule

//--- design/periph_top.sv
/* Peripheral configuration subsystem top level. An APB port feeds the bridge
   and decoder, which reach the boot ROM, NumFll FLL blocks and scratch memory. */
module periph_top #(
  parameter int unsigned NumFll       = 3,
  parameter int unsigned SettleCycles = 20,
  parameter int unsigned MemWords     = 256,
  parameter int unsigned MemLatency   = 3
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [periph_pkg::AddrWidth-1:0] paddr_i,
  input  logic [periph_pkg::DataWidth-1:0] pwdata_i,
  output logic [periph_pkg::DataWidth-1:0] prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  output periph_pkg::fll_cfg_u             fll_cfg_o [NumFll],
  output logic [NumFll-1:0]                fll_locked_o
);

  periph_pkg::reg_req_t bus_req;
  periph_pkg::reg_rsp_t bus_rsp;
  periph_pkg::reg_req_t rom_req;
  periph_pkg::reg_rsp_t rom_rsp;
  periph_pkg::reg_req_t mem_req;
  periph_pkg::reg_rsp_t mem_rsp;
  periph_pkg::reg_req_t fll_req [NumFll];
  periph_pkg::reg_rsp_t fll_rsp [NumFll];

  // ==============================
  // bridge and decoder
  // ==============================
  apb_to_reg i_apb_to_reg (
    .clk_i,
    .reset_i,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .paddr_i,
    .pwdata_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .reg_req_o (bus_req),
    .reg_rsp_i (bus_rsp)
  );

  periph_addr_decode #(
    .NumFll (NumFll)
  ) i_addr_decode (
    .clk_i,
    .reset_i,
    .req_i     (bus_req),
    .rsp_o     (bus_rsp),
    .rom_req_o (rom_req),
    .rom_rsp_i (rom_rsp),
    .fll_req_o (fll_req),
    .fll_rsp_i (fll_rsp),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp)
  );

  // ==============================
  // targets
  // ==============================
  bootrom_regs i_bootrom (
    .clk_i,
    .reset_i,
    .req_i (rom_req),
    .rsp_o (rom_rsp)
  );

  for (genvar n = 0; n < NumFll; n++) begin : gen_fll
    fll_regs #(
      .SettleCycles (SettleCycles)
    ) i_fll (
      .clk_i,
      .reset_i,
      .req_i     (fll_req[n]),
      .rsp_o     (fll_rsp[n]),
      .clk_cfg_o (fll_cfg_o[n]),
      .locked_o  (fll_locked_o[n])
    );
  end

  regbus_mem #(
    .Words      (MemWords),
    .MemLatency (MemLatency)
  ) i_mem (
    .clk_i,
    .reset_i,
    .req_i (mem_req),
    .rsp_o (mem_rsp)
  );

endmodule

//--- tb/periph_top_sva.sv
/* APB protocol and register-bus assertions, bound into periph_top.
   Covers access-phase hold, one selected target and quiet outputs in reset. */
module periph_top_sva #(
  parameter int unsigned NumFll = 3
) (
  input logic                             clk_i,
  input logic                             reset_i,
  input logic                             psel_i,
  input logic                             penable_i,
  input logic                             pwrite_i,
  input logic [periph_pkg::AddrWidth-1:0] paddr_i,
  input logic [periph_pkg::DataWidth-1:0] pwdata_i,
  input logic                             pready_o,
  input logic [NumFll-1:0]                fll_locked_o,
  input periph_pkg::reg_req_t             rom_req_i,
  input periph_pkg::reg_rsp_t             rom_rsp_i,
  input periph_pkg::reg_req_t             mem_req_i,
  input periph_pkg::reg_rsp_t             mem_rsp_i,
  input periph_pkg::reg_req_t             fll_req_i [NumFll],
  input periph_pkg::reg_rsp_t             fll_rsp_i [NumFll]
);

  int unsigned       fail_cnt = 0;
  logic [NumFll+1:0] valids;
  logic [NumFll+1:0] readys;

  always_comb begin
    valids[0] = rom_req_i.valid;
    valids[1] = mem_req_i.valid;
    readys[0] = rom_rsp_i.ready;
    readys[1] = mem_rsp_i.ready;
    for (int n = 0; n < NumFll; n++) begin
      valids[n+2] = fll_req_i[n].valid;
      readys[n+2] = fll_rsp_i[n].ready;
    end
  end

  // ==============================
  // properties
  // ==============================
  apb_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    psel_i && penable_i && !pready_o |=>
      psel_i && penable_i && $stable(paddr_i) && $stable(pwrite_i) && $stable(pwdata_i))
    else begin
      $error("apb access phase changed before pready");
      fail_cnt++;
    end

  one_target: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(valids))
    else begin
      $error("more than one target valid");
      fail_cnt++;
    end

  quiet_in_reset: assert property (@(posedge clk_i)
    reset_i ##1 reset_i |-> !pready_o && fll_locked_o == '0 && readys == '0)
    else begin
      $error("ready or lock high during reset");
      fail_cnt++;
    end

endmodule

bind periph_top periph_top_sva #(
  .NumFll (NumFll)
) sva_i (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .psel_i       (psel_i),
  .penable_i    (penable_i),
  .pwrite_i     (pwrite_i),
  .paddr_i      (paddr_i),
  .pwdata_i     (pwdata_i),
  .pready_o     (pready_o),
  .fll_locked_o (fll_locked_o),
  .rom_req_i    (rom_req),
  .rom_rsp_i    (rom_rsp),
  .mem_req_i    (mem_req),
  .mem_rsp_i    (mem_rsp),
  .fll_req_i    (fll_req),
  .fll_rsp_i    (fll_rsp)
);

//--- tb/tb_periph_top.sv
/* Directed testbench for periph_top. Drives APB transfers into the boot ROM,
   scratch memory, FLL blocks and unmapped holes, and checks every response. */
module tb_periph_top;

  localparam int unsigned NumFll       = 3;
  localparam int unsigned SettleCycles = 20;
  localparam int unsigned MemWords     = 256;
  localparam int unsigned MemLatency   = 3;
  localparam int unsigned Timeout      = 50;
  localparam int unsigned MemTests     = 32;

  logic                             clk;
  logic                             reset;
  logic                             psel;
  logic                             penable;
  logic                             pwrite;
  logic [periph_pkg::AddrWidth-1:0] paddr;
  logic [periph_pkg::DataWidth-1:0] pwdata;
  logic [periph_pkg::DataWidth-1:0] prdata;
  logic                             pready;
  logic                             pslverr;
  periph_pkg::fll_cfg_u             fll_cfg [NumFll];
  logic [NumFll-1:0]                fll_locked;

  int unsigned n_checks;
  int unsigned n_errors;
  int unsigned sva_fails;
  int unsigned last_stall;  // access-phase cycles before pready.
  logic [15:0] lfsr_q;
  logic [31:0] cfg_model [NumFll];

  periph_top #(
    .NumFll       (NumFll),
    .SettleCycles (SettleCycles),
    .MemWords     (MemWords),
    .MemLatency   (MemLatency)
  ) dut_i (
    .clk_i        (clk),
    .reset_i      (reset),
    .psel_i       (psel),
    .penable_i    (penable),
    .pwrite_i     (pwrite),
    .paddr_i      (paddr),
    .pwdata_i     (pwdata),
    .prdata_o     (prdata),
    .pready_o     (pready),
    .pslverr_o    (pslverr),
    .fll_cfg_o    (fll_cfg),
    .fll_locked_o (fll_locked)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==============================
  // helpers
  // ==============================
  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("MISMATCH %s: expected 0x%08h, got 0x%08h", name, exp, act);
    end
  endtask

  // galois lfsr stepped once for each bit taken.
  function automatic logic [31:0] lfsr_bits(input int unsigned n);
    logic [31:0] val;
    logic        b;
    val = '0;
    for (int i = 0; i < n; i++) begin
      b      = lfsr_q[0];
      lfsr_q = {1'b0, lfsr_q[15:1]} ^ (b ? 16'hB400 : 16'h0000);
      val    = {val[30:0], b};
    end
    return val;
  endfunction

  function automatic logic [15:0] scatter_addr(input int unsigned k);
    return 16'h8000 + 16'(((k * 37 + 5) % MemWords) * 4);  // odd stride so no word repeats.
  endfunction

  function automatic logic [15:0] fll_addr(input int unsigned n, input int unsigned off);
    return 16'h1000 + 16'(n * 256) + 16'(off);
  endfunction

  function automatic logic [31:0] open_cfg(input logic en, input logic [15:0] dco);
    return {1'b0, en, 14'b0, dco};
  endfunction

  function automatic logic [31:0] closed_cfg(input logic en, input logic [9:0] mult,
                                             input logic [3:0] div_exp);
    return {1'b1, en, 16'b0, mult, div_exp};
  endfunction

  // ==============================
  // apb driver
  // ==============================
  task automatic apb_xfer(input logic write, input logic [15:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int unsigned waited;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    waited = 0;
    @(posedge clk);
    while (!pready && waited < Timeout) begin
      waited++;
      @(posedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    if (!pready) begin
      n_errors++;
      $display("timeout: no pready within %0d cycles at address 0x%04h", Timeout, addr);
    end
    last_stall = waited;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [15:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [15:0] addr, output logic [31:0] data, output logic err);
    apb_xfer(1'b0, addr, 32'h0, data, err);
  endtask

  task automatic check_all_cfg();
    for (int n = 0; n < NumFll; n++) begin
      check("fll_cfg_o", cfg_model[n], fll_cfg[n]);
    end
  endtask

  // ==============================
  // directed tests
  // ==============================
  task automatic test_bootrom();
    logic [31:0] rd;
    logic        err;
    for (int k = 0; k < 16; k++) begin
      apb_read(16'(k * 4), rd, err);
      check("prdata", 32'hB007_0000 + k, rd);
      check("pslverr", 32'h0, err);
      check("pready delay", 32'h1, last_stall);
    end
    apb_read(16'h0050, rd, err);  // word 20 lies past the stub.
    check("prdata", 32'h0, rd);
    check("pslverr", 32'h0, err);
    apb_write(16'h0008, 32'hDEAD_BEEF, err);
    check("pslverr", 32'h1, err);
    apb_read(16'h0008, rd, err);
    check("prdata", 32'hB007_0002, rd);
  endtask

  task automatic test_memory();
    logic [31:0] data [MemTests];
    logic [31:0] rd;
    logic        err;
    for (int k = 0; k < MemTests; k++) begin
      data[k] = lfsr_bits(32);
      apb_write(scatter_addr(k), data[k], err);
      check("pslverr", 32'h0, err);
      check("pready delay", MemLatency, last_stall);
    end
    for (int k = 0; k < MemTests; k++) begin
      apb_read(scatter_addr(k), rd, err);
      check("prdata", data[k], rd);
      check("pslverr", 32'h0, err);
      check("pready delay", MemLatency, last_stall);
    end
  endtask

  task automatic test_fll_views();
    logic [31:0] cfg;
    logic [31:0] rd;
    logic        err;
    logic [15:0] dco;
    logic [9:0]  mult;
    logic [3:0]  dexp;
    for (int n = 0; n < NumFll; n++) begin
      dco = 16'h1230 + 16'(n);
      cfg = open_cfg(1'b0, dco);
      apb_write(fll_addr(n, 0), cfg, err);
      check("pslverr", 32'h0, err);
      cfg_model[n] = cfg;
      apb_read(fll_addr(n, 0), rd, err);
      check("cfg readback", cfg, rd);
      check_all_cfg();
      apb_read(fll_addr(n, 4), rd, err);
      check("status loop value", {16'h0, dco}, {16'h0, rd[31:16]});
      // in closed loop status shows factor >> exponent.
      mult = 10'h2A5 + 10'(n);
      dexp = 4'(n + 2);
      cfg  = closed_cfg(1'b0, mult, dexp);
      apb_write(fll_addr(n, 0), cfg, err);
      check("pslverr", 32'h0, err);
      cfg_model[n] = cfg;
      apb_read(fll_addr(n, 0), rd, err);
      check("cfg readback", cfg, rd);
      check_all_cfg();
      apb_read(fll_addr(n, 4), rd, err);
      check("status loop value", {22'h0, mult >> dexp}, {16'h0, rd[31:16]});
    end
  endtask

  task automatic test_lock(input int unsigned n);
    logic [31:0] cfg;
    logic [31:0] rd;
    logic        err;
    int unsigned waited;
    cfg = open_cfg(1'b1, 16'h0400);
    apb_write(fll_addr(n, 0), cfg, err);
    check("pslverr", 32'h0, err);
    cfg_model[n] = cfg;
    check("fll_locked_o", 32'h0, fll_locked[n]);
    waited = 0;
    while (!fll_locked[n] && waited < SettleCycles + 5) begin
      @(posedge clk);
      waited++;
    end
    if (!fll_locked[n]) begin
      n_errors++;
      $display("FLL %0d did not lock within %0d cycles", n, SettleCycles + 5);
    end
    check("fll_locked_o", 32'h0, fll_locked & ~(NumFll'(1) << n));
    apb_read(fll_addr(n, 4), rd, err);
    check("status locked", 32'h1, rd[0]);
    check("status loop value", 32'h0400, {16'h0, rd[31:16]});
  endtask

  task automatic check_recovery();
    logic [31:0] rd;
    logic        err;
    apb_read(16'h0004, rd, err);
    check("prdata", 32'hB007_0001, rd);
    check("pslverr", 32'h0, err);
  endtask

  task automatic test_errors();
    logic [31:0] rd;
    logic        err;
    apb_read(16'h1300, rd, err);  // fll index past NumFll.
    check("pslverr", 32'h1, err);
    check("pready delay", 32'h1, last_stall);
    check_recovery();
    apb_read(16'h4000, rd, err);
    check("pslverr", 32'h1, err);
    check_recovery();
    apb_write(fll_addr(0, 4), 32'hFFFF_FFFF, err);
    check("pslverr", 32'h1, err);
    check_all_cfg();
    check_recovery();
    apb_read(fll_addr(2, 8), rd, err);
    check("pslverr", 32'h1, err);
    check_recovery();
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    n_checks = 0;
    n_errors = 0;
    lfsr_q   = 16'd94;
    reset    = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    for (int n = 0; n < NumFll; n++) begin
      cfg_model[n] = '0;
    end
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    check_all_cfg();
    check("fll_locked_o", 32'h0, fll_locked);
    test_bootrom();
    test_memory();
    test_fll_views();
    test_lock(1);
    test_lock(1);  // a locked FLL must drop lock on the new write.
    test_errors();
    repeat (2) @(posedge clk);
    sva_fails = dut_i.sva_i.fail_cnt;
    $display("checks: %0d  errors: %0d  assertion failures: %0d",
             n_checks, n_errors, sva_fails);
    if (n_errors == 0 && sva_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- periph_sys.f
design/periph_pkg.sv
design/apb_to_reg.sv
design/periph_addr_decode.sv
design/bootrom_regs.sv
design/fll_regs.sv
design/regbus_mem.sv
design/periph_top.sv
tb/periph_top_sva.sv
tb/tb_periph_top.sv

//--- Bender.yml
package:
  name: periph_sys

sources:
  - design/periph_pkg.sv
  - design/apb_to_reg.sv
  - design/periph_addr_decode.sv
  - design/bootrom_regs.sv
  - design/fll_regs.sv
  - design/regbus_mem.sv
  - design/periph_top.sv
  - target: test
    files:
      - tb/periph_top_sva.sv
      - tb/tb_periph_top.sv
